// File: imu_states.f
source/imu_pkg.sv
source/spi_master.sv
source/spi_arbiter.sv
source/imu_config_writer.sv
source/imu_sample_reader.sv
source/imu_states.sv
verif/imu_spi_model.sv
verif/imu_states_assert.sv
verif/imu_states_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the IMU front end testbench with Verilator
rm -rf obj_dir build.log sim.log
verilator --binary --top-module imu_states_tb -f imu_states.f -o imu_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/imu_sim > sim.log 2>&1
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
  || grep -q "Result: PASSED" sim.log && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation ended without a verdict"; exit 1; }

// File: source/imu_config_writer.sv
/*
  Sensor start-up sequencer
  Warm-up wait, then one SPI write per table entry with a gap after each
*/
`timescale 1ns/1ns
`default_nettype none

module imu_config_writer (
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire logic         finish,
  output logic              req,
  output imu_pkg::spi_req_t txn,
  output logic              config_done
);

  imu_pkg::cfg_state_t  state;
  imu_pkg::warmup_cnt_t warm_cnt;
  imu_pkg::gap_cnt_t    gap_cnt;
  imu_pkg::cfg_idx_t    idx;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= imu_pkg::CFG_WARMUP;
      warm_cnt <= '0;
      gap_cnt  <= '0;
      idx      <= '0;
    end else begin
      case (state)
        imu_pkg::CFG_WARMUP: begin
          // Sensor power-up time
          warm_cnt <= warm_cnt + 1'b1;
          if (warm_cnt == imu_pkg::warmup_cnt_t'(imu_pkg::WARMUP_CYCLES - 1)) begin
            state <= imu_pkg::CFG_WRITE;
          end
        end
        imu_pkg::CFG_WRITE: begin
          // Request held until our finish
          if (finish) begin
            gap_cnt <= '0;
            state   <= imu_pkg::CFG_GAP;
          end
        end
        imu_pkg::CFG_GAP: begin
          // Let the register settle
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_cnt == imu_pkg::gap_cnt_t'(imu_pkg::CFG_GAP_CYCLES - 1)) begin
            if (idx == imu_pkg::cfg_idx_t'(imu_pkg::CFG_COUNT - 1)) begin
              state <= imu_pkg::CFG_DONE;
            end else begin
              idx   <= idx + 1'b1;
              state <= imu_pkg::CFG_WRITE;
            end
          end
        end
        imu_pkg::CFG_DONE: begin
          // Terminal, stays configured
          state <= imu_pkg::CFG_DONE;
        end
        default: state <= imu_pkg::CFG_WARMUP;
      endcase
    end
  end

  assign req         = (state == imu_pkg::CFG_WRITE);
  assign config_done = (state == imu_pkg::CFG_DONE);

  // Single-byte write from the current table entry
  always_comb begin
    txn.rd    = 1'b0;
    txn.addr  = imu_pkg::CFG_TABLE[idx].addr;
    txn.wdata = imu_pkg::CFG_TABLE[idx].data;
    txn.len   = imu_pkg::burst_len_t'(1);
  end

endmodule

`default_nettype wire

// File: source/imu_pkg.sv
/*
  Shared types, SPI transaction structs and FSM state enums for the IMU front end
  Timing constants and the sensor configuration table
*/
`default_nettype none

package imu_pkg;

  // Clock counts
  localparam int SPI_HALF_CYCLES = 4;
  localparam int WARMUP_CYCLES   = 200;
  localparam int CFG_GAP_CYCLES  = 32;

  // Configuration table size
  localparam int CFG_COUNT = 7;

  // Basic field widths
  typedef logic [6:0]  reg_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [47:0] acc_t;
  typedef logic [2:0]  burst_len_t;

  // Counter widths tied to the constants above
  typedef logic [$clog2(SPI_HALF_CYCLES)-1:0] half_cnt_t;
  typedef logic [$clog2(WARMUP_CYCLES)-1:0]   warmup_cnt_t;
  typedef logic [$clog2(CFG_GAP_CYCLES)-1:0]  gap_cnt_t;
  typedef logic [$clog2(CFG_COUNT)-1:0]       cfg_idx_t;

  // Accelerometer burst, X/Y/Z high then low
  localparam reg_addr_t ACC_BASE_ADDR = 7'h3B;
  localparam int        ACC_BYTES     = 6;

  // One register write of the start-up sequence
  typedef struct packed {
    reg_addr_t addr;
    byte_t     data;
  } cfg_entry_t;

  // Reset, wake, sensor enable, rate divider, DLPF, gyro range, accel range
  localparam cfg_entry_t CFG_TABLE [CFG_COUNT] = '{
    '{addr: 7'h6B, data: 8'h80},
    '{addr: 7'h6B, data: 8'h00},
    '{addr: 7'h6C, data: 8'h00},
    '{addr: 7'h19, data: 8'h00},
    '{addr: 7'h1A, data: 8'h01},
    '{addr: 7'h1B, data: 8'h10},
    '{addr: 7'h1C, data: 8'h10}
  };

  // Request to the SPI master
  typedef struct packed {
    logic       rd;
    reg_addr_t  addr;
    byte_t      wdata;
    burst_len_t len;
  } spi_req_t;

  // Read byte from the SPI master
  typedef struct packed {
    byte_t data;
    logic  strobe;
  } spi_rsp_t;

  typedef enum logic [1:0] {CFG_WARMUP, CFG_WRITE, CFG_GAP, CFG_DONE} cfg_state_t;
  typedef enum logic [1:0] {RD_IDLE, RD_REQUEST, RD_COLLECT} rd_state_t;
  typedef enum logic [1:0] {SPI_IDLE, SPI_SELECT, SPI_SHIFT, SPI_DESELECT} spi_state_t;

endpackage

`default_nettype wire

// File: source/imu_sample_reader.sv
/*
  Tick-driven accelerometer burst reader
  Collects six bytes and publishes one 48-bit sample with a valid pulse
*/
`timescale 1ns/1ns
`default_nettype none

module imu_sample_reader (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              tmr_1khz,
  input  wire logic              finish,
  input  wire imu_pkg::spi_rsp_t rsp,
  output logic                   req,
  output imu_pkg::spi_req_t      txn,
  output imu_pkg::acc_t          acc,
  output logic                   acc_valid
);

  imu_pkg::rd_state_t state;
  imu_pkg::acc_t      work;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= imu_pkg::RD_IDLE;
      acc       <= '0;
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= 1'b0;
      case (state)
        imu_pkg::RD_IDLE: begin
          // Ticks only count here
          if (tmr_1khz) begin
            state <= imu_pkg::RD_REQUEST;
          end
        end
        imu_pkg::RD_REQUEST: begin
          // Waiting for grant and the first byte
          if (rsp.strobe) begin
            state <= imu_pkg::RD_COLLECT;
          end
        end
        imu_pkg::RD_COLLECT: begin
          if (finish) begin
            acc       <= work;
            acc_valid <= 1'b1;
            state     <= imu_pkg::RD_IDLE;
          end
        end
        default: state <= imu_pkg::RD_IDLE;
      endcase
    end
  end

  // First byte ends up in the top bits
  always_ff @(posedge clk) begin
    if (rsp.strobe) begin
      work <= {work[$bits(imu_pkg::acc_t)-9:0], rsp.data};
    end
  end

  assign req = (state != imu_pkg::RD_IDLE);

  // Burst read from the accel base register
  always_comb begin
    txn.rd    = 1'b1;
    txn.addr  = imu_pkg::ACC_BASE_ADDR;
    txn.wdata = '0;
    txn.len   = imu_pkg::burst_len_t'(imu_pkg::ACC_BYTES);
  end

endmodule

`default_nettype wire

// File: source/imu_states.sv
/*
  IMU front end top level
  Config writer and sample reader sharing one SPI master via the arbiter
*/
`timescale 1ns/1ns
`default_nettype none

module imu_states (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     tmr_1khz,
  input  wire logic     imu_miso,
  output logic          imu_mosi,
  output logic          imu_sclk,
  output logic          imu_ss,
  output logic          config_done,
  output logic          acc_valid,
  output imu_pkg::acc_t acc
);

  // Peer requests
  logic              cfg_req;
  logic              rd_req;
  imu_pkg::spi_req_t cfg_txn;
  imu_pkg::spi_req_t rd_txn;

  // Arbiter to master
  logic              start;
  imu_pkg::spi_req_t txn;
  logic              busy;
  logic              finish;
  logic              cfg_finish;
  logic              rd_finish;
  imu_pkg::spi_rsp_t rsp;

  imu_config_writer i_config_writer (
    .clk         (clk),
    .rst         (rst),
    .finish      (cfg_finish),
    .req         (cfg_req),
    .txn         (cfg_txn),
    .config_done (config_done)
  );

  imu_sample_reader i_sample_reader (
    .clk       (clk),
    .rst       (rst),
    .tmr_1khz  (tmr_1khz),
    .finish    (rd_finish),
    .rsp       (rsp),
    .req       (rd_req),
    .txn       (rd_txn),
    .acc       (acc),
    .acc_valid (acc_valid)
  );

  spi_arbiter i_spi_arbiter (
    .clk        (clk),
    .rst        (rst),
    .cfg_req    (cfg_req),
    .rd_req     (rd_req),
    .cfg_txn    (cfg_txn),
    .rd_txn     (rd_txn),
    .busy       (busy),
    .finish     (finish),
    .start      (start),
    .txn        (txn),
    .cfg_finish (cfg_finish),
    .rd_finish  (rd_finish)
  );

  spi_master i_spi_master (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .req    (txn),
    .miso   (imu_miso),
    .sclk   (imu_sclk),
    .mosi   (imu_mosi),
    .ss     (imu_ss),
    .busy   (busy),
    .finish (finish),
    .rsp    (rsp)
  );

endmodule

`default_nettype wire

// File: source/spi_arbiter.sv
/*
  Fixed-priority arbiter for the shared SPI master
  Config writer wins, grant held until finish
*/
`timescale 1ns/1ns
`default_nettype none

module spi_arbiter (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              cfg_req,
  input  wire logic              rd_req,
  input  wire imu_pkg::spi_req_t cfg_txn,
  input  wire imu_pkg::spi_req_t rd_txn,
  input  wire logic              busy,
  input  wire logic              finish,
  output logic                   start,
  output imu_pkg::spi_req_t      txn,
  output logic                   cfg_finish,
  output logic                   rd_finish
);

  // Transaction in flight
  logic active;
  // Grant owner, 1 for the reader
  logic grant_rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      grant_rd <= 1'b0;
      start    <= 1'b0;
    end else begin
      start <= 1'b0;
      if (active) begin
        // Release at end of transaction
        if (finish) begin
          active <= 1'b0;
        end
      end else if (!busy && (cfg_req || rd_req)) begin
        // Writer has priority
        active   <= 1'b1;
        start    <= 1'b1;
        grant_rd <= !cfg_req;
      end
    end
  end

  // Peers hold their request stable until finish
  assign txn = grant_rd ? rd_txn : cfg_txn;

  // Finish goes back to the owner only
  assign cfg_finish = finish && active && !grant_rd;
  assign rd_finish  = finish && active && grant_rd;

endmodule

`default_nettype wire

// File: source/spi_master.sv
/*
  Mode-3 SPI master
  Address byte followed by a burst of write or read data bytes
*/
`timescale 1ns/1ns
`default_nettype none

module spi_master (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             start,
  input  wire imu_pkg::spi_req_t req,
  input  wire logic             miso,
  output logic                  sclk,
  output logic                  mosi,
  output logic                  ss,
  output logic                  busy,
  output logic                  finish,
  output imu_pkg::spi_rsp_t     rsp
);

  imu_pkg::spi_state_t state;
  imu_pkg::spi_req_t   cur;
  imu_pkg::half_cnt_t  half_cnt;
  imu_pkg::burst_len_t byte_cnt;
  logic [2:0]          bit_cnt;
  imu_pkg::byte_t      tx_sr;
  imu_pkg::byte_t      rx_sr;
  imu_pkg::byte_t      next_byte;
  logic                end_q;

  // Data bytes: write value, or zeros while reading
  assign next_byte = cur.rd ? '0 : cur.wdata;

  // Busy until SS is back high and the finish pulse is due
  assign busy = (state != imu_pkg::SPI_IDLE) || end_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= imu_pkg::SPI_IDLE;
      ss         <= 1'b1;
      sclk       <= 1'b1;
      mosi       <= 1'b0;
      end_q      <= 1'b0;
      finish     <= 1'b0;
      rsp.strobe <= 1'b0;
      half_cnt   <= '0;
      bit_cnt    <= '0;
      byte_cnt   <= '0;
    end else begin
      // One-cycle pulses by default
      end_q      <= 1'b0;
      finish     <= end_q;
      rsp.strobe <= 1'b0;
      case (state)
        imu_pkg::SPI_IDLE: begin
          if (start) begin
            // Latch request, first byte is R/W flag plus address
            cur      <= req;
            tx_sr    <= {req.rd, req.addr};
            byte_cnt <= '0;
            ss       <= 1'b0;
            state    <= imu_pkg::SPI_SELECT;
          end
        end
        imu_pkg::SPI_SELECT: begin
          // First falling edge, MSB out
          sclk     <= 1'b0;
          mosi     <= tx_sr[7];
          tx_sr    <= {tx_sr[6:0], 1'b0};
          half_cnt <= '0;
          bit_cnt  <= '0;
          state    <= imu_pkg::SPI_SHIFT;
        end
        imu_pkg::SPI_SHIFT: begin
          half_cnt <= half_cnt + 1'b1;
          if (half_cnt == imu_pkg::half_cnt_t'(imu_pkg::SPI_HALF_CYCLES - 1)) begin
            half_cnt <= '0;
            if (!sclk) begin
              // Rising edge, sample MISO
              sclk  <= 1'b1;
              rx_sr <= {rx_sr[6:0], miso};
            end else if (bit_cnt != 3'd7) begin
              // Falling edge inside a byte
              sclk    <= 1'b0;
              mosi    <= tx_sr[7];
              tx_sr   <= {tx_sr[6:0], 1'b0};
              bit_cnt <= bit_cnt + 1'b1;
            end else begin
              // Byte boundary
              if (cur.rd && (byte_cnt != '0)) begin
                rsp.data   <= rx_sr;
                rsp.strobe <= 1'b1;
              end
              if (byte_cnt == cur.len) begin
                state <= imu_pkg::SPI_DESELECT;
              end else begin
                byte_cnt <= byte_cnt + 1'b1;
                sclk     <= 1'b0;
                mosi     <= next_byte[7];
                tx_sr    <= {next_byte[6:0], 1'b0};
                bit_cnt  <= '0;
              end
            end
          end
        end
        imu_pkg::SPI_DESELECT: begin
          // SCLK already high here
          ss    <= 1'b1;
          mosi  <= 1'b0;
          end_q <= 1'b1;
          state <= imu_pkg::SPI_IDLE;
        end
        default: state <= imu_pkg::SPI_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verif/imu_spi_model.sv
/*
  Behavioural SPI slave of the inertial sensor, mode 3
  Register image, write log and per-frame record
*/
`timescale 1ns/1ns
`default_nettype none

module imu_spi_model (
  input  wire logic ss,
  input  wire logic sclk,
  input  wire logic mosi,
  output logic      miso
);

  imu_pkg::byte_t image [128];

  // Writes in arrival order
  imu_pkg::reg_addr_t wr_addr [$];
  imu_pkg::byte_t     wr_data [$];

  // One entry per completed frame
  logic               frame_rd   [$];
  imu_pkg::reg_addr_t frame_addr [$];
  int                 frame_bits [$];
  imu_pkg::acc_t      frame_acc  [$];

  int                 bits;
  logic               rd;
  logic               framed;
  imu_pkg::reg_addr_t addr;
  imu_pkg::reg_addr_t ptr;
  imu_pkg::byte_t     rx_sr;
  imu_pkg::byte_t     tx_sr;
  imu_pkg::acc_t      served;

  initial begin
    // Fill pattern over the whole address
    for (int i = 0; i < 128; i++) begin
      image[i] = imu_pkg::byte_t'(i * 37 + 11);
    end
    miso   = 1'b0;
    bits   = 0;
    rd     = 1'b0;
    framed = 1'b0;
    tx_sr  = '0;
  end

  // Frame opens on SS falling
  always @(negedge ss) begin
    framed = 1'b1;
    bits   = 0;
    tx_sr  = '0;
  end

  // Sensor samples MOSI on the rising edge
  always @(posedge sclk) begin
    if (!ss) begin
      rx_sr = {rx_sr[6:0], mosi};
      bits++;
      if (bits % 8 == 0) begin
        if (bits == 8) begin
          // Address byte, R/W flag on top
          rd   = rx_sr[7];
          addr = rx_sr[6:0];
          ptr  = addr;
          served = '0;
          for (int k = 0; k < imu_pkg::ACC_BYTES; k++) begin
            served = {served[39:0], image[imu_pkg::reg_addr_t'(int'(addr) + k)]};
          end
          if (rd) tx_sr = image[ptr];
        end else if (rd) begin
          // Auto-increment through the burst
          ptr   = ptr + 7'd1;
          tx_sr = image[ptr];
        end else if (bits == 16) begin
          wr_addr.push_back(addr);
          wr_data.push_back(rx_sr);
          image[addr] = rx_sr;
        end
      end
    end
  end

  // MISO changes on the falling edge
  always @(negedge sclk) begin
    if (!ss) begin
      miso  = tx_sr[7];
      tx_sr = {tx_sr[6:0], 1'b0};
    end
  end

  // SS rising out of reset closes no frame
  always @(posedge ss) begin
    if (framed) begin
      framed = 1'b0;
      frame_rd.push_back(rd);
      frame_addr.push_back(addr);
      frame_bits.push_back(bits);
      if (rd) frame_acc.push_back(served);
    end
  end

endmodule

`default_nettype wire

// File: verif/imu_states_assert.sv
/*
  Concurrent checks on arbiter grants and SPI framing
  Bound into the top level where arbiter and master meet
*/
`timescale 1ns/1ns
`default_nettype none

module imu_states_assert (
  input wire logic clk,
  input wire logic rst,
  input wire logic busy,
  input wire logic start,
  input wire logic grant,
  input wire logic ss,
  input wire logic sclk
);

  // Owner fixed for the whole transaction
  a_grant_stable: assert property (@(posedge clk) disable iff (rst) busy |=> $stable(grant))
    else $error("grant changed while the master was busy");

  // New transaction only on an idle master
  a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
    else $error("start while the master was busy");

  // Mode 3, SCLK idles high
  a_sclk_idle: assert property (@(posedge clk) disable iff (rst) ss |-> sclk)
    else $error("SCLK low while SS high");

endmodule

bind imu_states imu_states_assert u_assert (
  .clk   (clk),
  .rst   (rst),
  .busy  (busy),
  .start (start),
  .grant (i_spi_arbiter.grant_rd),
  .ss    (imu_ss),
  .sclk  (imu_sclk)
);

`default_nettype wire

// File: verif/imu_states_tb.sv
/*
  Testbench for the IMU front end
  Random ticks, sensor model, write log and sample checks, watchdog
*/
`timescale 1ns/1ns
`default_nettype none

module imu_states_tb;

  localparam int TXN_CYCLES = 7 * 16 * imu_pkg::SPI_HALF_CYCLES + 2;
  localparam int SAMPLES    = 40;
  // Warm-up, config writes with gaps, reads with tick and grant waits, doubled
  localparam int LIMIT_CYCLES = 2 * (10 + imu_pkg::WARMUP_CYCLES
    + imu_pkg::CFG_COUNT * (TXN_CYCLES + imu_pkg::CFG_GAP_CYCLES)
    + SAMPLES * (2 * TXN_CYCLES + 200));

  logic          clk;
  logic          rst;
  logic          tmr_1khz;
  logic          imu_miso;
  logic          imu_mosi;
  logic          imu_sclk;
  logic          imu_ss;
  logic          config_done;
  logic          acc_valid;
  imu_pkg::acc_t acc;

  int            ticks;
  int            samples;
  int            cycles;
  logic          f_rd;
  int            f_bits;
  imu_pkg::reg_addr_t f_addr;
  imu_pkg::acc_t exp_acc [$];

  imu_states i_imu_states (
    .clk         (clk),
    .rst         (rst),
    .tmr_1khz    (tmr_1khz),
    .imu_miso    (imu_miso),
    .imu_mosi    (imu_mosi),
    .imu_sclk    (imu_sclk),
    .imu_ss      (imu_ss),
    .config_done (config_done),
    .acc_valid   (acc_valid),
    .acc         (acc)
  );

  imu_spi_model i_spi_model (
    .ss   (imu_ss),
    .sclk (imu_sclk),
    .mosi (imu_mosi),
    .miso (imu_miso)
  );

  always #50 clk = ~clk;

  task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(input string msg);
    $display("%s (time %0t)", msg, $time);
    stop_run();
  endtask

  task automatic check_byte(input string name, input imu_pkg::byte_t got,
                            input imu_pkg::byte_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_addr(input string name, input imu_pkg::reg_addr_t got,
                            input imu_pkg::reg_addr_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_acc(input string name, input imu_pkg::acc_t got,
                           input imu_pkg::acc_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_int(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  // Stimulus, 1 ns after each rising edge
  initial begin
    void'($urandom(23));
    clk      = 1'b0;
    rst      = 1'b1;
    tmr_1khz = 1'b0;
    ticks    = 0;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    // Bus stays quiet while the sensor warms up
    repeat (imu_pkg::WARMUP_CYCLES) @(posedge clk);
    forever begin
      @(posedge clk);
      #1;
      tmr_1khz = ($urandom_range(99) < 3);
      if (tmr_1khz) ticks++;
    end
  end

  // Monitor on the falling edge, outputs settled
  always @(negedge clk) begin
    if (!rst) begin
      cycles++;
      if (cycles <= imu_pkg::WARMUP_CYCLES) begin
        check_bit("imu_ss", imu_ss, 1'b1);
        check_bit("imu_sclk", imu_sclk, 1'b1);
        check_bit("config_done", config_done, 1'b0);
        check_bit("acc_valid", acc_valid, 1'b0);
      end
      // Frame shape
      while (i_spi_model.frame_bits.size() > 0) begin
        f_rd   = i_spi_model.frame_rd.pop_front();
        f_addr = i_spi_model.frame_addr.pop_front();
        f_bits = i_spi_model.frame_bits.pop_front();
        if (f_rd) begin
          check_addr("read frame address", f_addr, imu_pkg::ACC_BASE_ADDR);
          check_int("read frame bits", f_bits, 8 * (imu_pkg::ACC_BYTES + 1));
          exp_acc.push_back(i_spi_model.frame_acc.pop_front());
        end else begin
          check_int("write frame bits", f_bits, 16);
        end
      end
      if (config_done) begin
        check_int("writes with config_done high", i_spi_model.wr_addr.size(),
                  imu_pkg::CFG_COUNT);
      end
      if (acc_valid) begin
        samples++;
        if (samples > ticks) report_failure("More samples than timer ticks");
        if (exp_acc.size() == 0) report_failure("Sample without a read frame");
        check_acc("acc", acc, exp_acc.pop_front());
        // Fresh sample registers for the next read
        for (int k = 0; k < imu_pkg::ACC_BYTES; k++) begin
          i_spi_model.image[imu_pkg::reg_addr_t'(int'(imu_pkg::ACC_BASE_ADDR) + k)] =
            imu_pkg::byte_t'($urandom);
        end
      end
    end
  end

  // End of run
  initial begin
    samples = 0;
    cycles  = 0;
    @(negedge rst);
    while (samples < SAMPLES) @(posedge clk);
    @(negedge clk);
    check_int("write count", i_spi_model.wr_addr.size(), imu_pkg::CFG_COUNT);
    for (int i = 0; i < imu_pkg::CFG_COUNT; i++) begin
      check_addr("write address", i_spi_model.wr_addr[i], imu_pkg::CFG_TABLE[i].addr);
      check_byte("write data", i_spi_model.wr_data[i], imu_pkg::CFG_TABLE[i].data);
    end
    check_bit("config_done", config_done, 1'b1);
    check_int("unchecked read frames", exp_acc.size(), 0);
    $display("Result: PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    report_failure("Watchdog timeout, not all samples arrived");
  end

endmodule

`default_nettype wire
